/* axi_pkg.sv */
package axi_pkg;

	// AXI-lite link geometry
	localparam int ADDR_W = 32; // Byte address
	localparam int DATA_W = 32; // One word per beat
	localparam int STRB_W = DATA_W / 8; // One strobe bit per byte lane

	// Response codes as they appear on RRESP and BRESP
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10, // Slave saw the access but refused it
		DECERR = 2'b11  // Nobody lives at this address
	} axi_resp_e;

endpackage

/* soc_pkg.sv */
package soc_pkg;

	// RAM window, decoded wide but only RAM_WORDS backed
	localparam logic [31:0] RAM_BASE  = 32'h0000_0000;
	localparam logic [31:0] RAM_SPACE = 32'h0002_ffff;
	// Boot controller register window
	localparam logic [31:0] BOOT_BASE  = 32'h0003_0000;
	localparam logic [31:0] BOOT_SPACE = 32'h0000_00ff;
	// Not decoded in this SoC, only jump targets for the boot code
	localparam logic [31:0] SPI_BASE = 32'h0006_0000;
	localparam logic [31:0] DDR_BASE = 32'h1000_0000;

	localparam int RAM_WORDS = 1024; // 4 KiB, aliases across the window
	localparam int RAM_IDX_W = $clog2(RAM_WORDS);

	// Boot controller register offsets
	localparam logic [7:0] BOOT_SRC_REG = 8'h00; // Strapped source, read only
	localparam logic [7:0] BOOT_VEC_REG = 8'h04; // Boot vector, read/write

	// Strapping pin encoding
	typedef enum logic [1:0] {
		BOOT_SPI  = 2'd0,
		BOOT_SRAM = 2'd1,
		BOOT_DDR  = 2'd2 // Pin value 3 falls back to SRAM
	} boot_src_e;

	// Decoder target
	typedef enum logic [1:0] {
		SEL_RAM,
		SEL_BOOT,
		SEL_NONE // Unmapped, decoder answers itself
	} slv_sel_e;

endpackage

/* cpu_mem_bridge.sv */
`timescale 1ns/1ps

module cpu_mem_bridge
	import axi_pkg::*;
(
	input  logic              clk_i,
	input  logic              reset_i,
	// CPU data port, strobes held until ready
	input  logic              mem_rd_i,
	input  logic              mem_wr_i,
	input  logic [ADDR_W-1:0] mem_addr_i,
	input  logic [DATA_W-1:0] mem_wdata_i,
	input  logic [STRB_W-1:0] mem_byte_sel_i,
	output logic              mem_ready_o, // One cycle pulse
	output logic [DATA_W-1:0] mem_rdata_o,
	output logic              bus_err_o,
	// AR channel
	output logic              m_arvalid_o,
	input  logic              m_arready_i,
	output logic [ADDR_W-1:0] m_araddr_o,
	// R channel
	input  logic              m_rvalid_i,
	output logic              m_rready_o,
	input  logic [DATA_W-1:0] m_rdata_i,
	input  axi_resp_e         m_rresp_i,
	// AW channel
	output logic              m_awvalid_o,
	input  logic              m_awready_i,
	output logic [ADDR_W-1:0] m_awaddr_o,
	// W channel
	output logic              m_wvalid_o,
	input  logic              m_wready_i,
	output logic [DATA_W-1:0] m_wdata_o,
	output logic [STRB_W-1:0] m_wstrb_o,
	// B channel
	input  logic              m_bvalid_i,
	output logic              m_bready_o,
	input  axi_resp_e         m_bresp_i
);

	typedef enum logic [2:0] {
		IDLE,
		READ_ADDR,
		READ_RESP,
		WRITE_REQ,
		WRITE_RESP,
		DONE
	} state_e;

	state_e            state_q;
	logic              aw_done_q, w_done_q; // Write channels already transferred
	logic              aw_fire, w_fire;
	logic [ADDR_W-1:0] addr_q;
	logic [DATA_W-1:0] wdata_q;
	logic [STRB_W-1:0] strb_q;
	logic [DATA_W-1:0] rdata_q;
	logic              err_q;

	assign aw_fire = m_awvalid_o & m_awready_i;
	assign w_fire  = m_wvalid_o & m_wready_i;

	// Request payload, frozen once we leave IDLE
	always_ff @(posedge clk_i) begin
		if (state_q == IDLE) begin
			addr_q  <= mem_addr_i;
			wdata_q <= mem_wdata_i;
			strb_q  <= mem_byte_sel_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state_q   <= IDLE;
			aw_done_q <= 1'b0;
			w_done_q  <= 1'b0;
			err_q     <= 1'b0;
		end else begin
			case (state_q)
				IDLE: begin
					aw_done_q <= 1'b0;
					w_done_q  <= 1'b0;
					if (mem_rd_i)
						state_q <= READ_ADDR; // Read wins if both strobes are up
					else if (mem_wr_i)
						state_q <= WRITE_REQ;
				end
				READ_ADDR:
					if (m_arready_i)
						state_q <= READ_RESP;
				READ_RESP:
					if (m_rvalid_i) begin
						err_q   <= (m_rresp_i != OKAY);
						state_q <= DONE;
					end
				WRITE_REQ: begin
					// AW and W may land in different cycles
					if (aw_fire)
						aw_done_q <= 1'b1;
					if (w_fire)
						w_done_q <= 1'b1;
					if ((aw_done_q | aw_fire) & (w_done_q | w_fire))
						state_q <= WRITE_RESP;
				end
				WRITE_RESP:
					if (m_bvalid_i) begin
						err_q   <= (m_bresp_i != OKAY);
						state_q <= DONE;
					end
				default:
					state_q <= IDLE; // DONE lasts one cycle
			endcase
		end
	end

	// Read data back to the CPU
	always_ff @(posedge clk_i) begin
		if (m_rvalid_i & m_rready_o)
			rdata_q <= m_rdata_i;
		else if (m_bvalid_i & m_bready_o)
			rdata_q <= '0; // Writes return zero
	end

	assign m_arvalid_o = (state_q == READ_ADDR);
	assign m_araddr_o  = addr_q;
	assign m_rready_o  = (state_q == READ_RESP);
	assign m_awvalid_o = (state_q == WRITE_REQ) & ~aw_done_q;
	assign m_awaddr_o  = addr_q;
	assign m_wvalid_o  = (state_q == WRITE_REQ) & ~w_done_q;
	assign m_wdata_o   = wdata_q;
	assign m_wstrb_o   = strb_q;
	assign m_bready_o  = (state_q == WRITE_RESP);
	assign mem_ready_o = (state_q == DONE);
	assign mem_rdata_o = rdata_q;
	assign bus_err_o   = err_q;

endmodule

/* axi_decoder.sv */
`timescale 1ns/1ps

module axi_decoder
	import axi_pkg::*;
	import soc_pkg::*;
(
	input  logic              clk_i,
	input  logic              reset_i,
	// From the bridge
	input  logic              s_arvalid_i, s_awvalid_i, s_wvalid_i,
	output logic              s_arready_o, s_awready_o, s_wready_o,
	output logic              s_rvalid_o, s_bvalid_o,
	input  logic              s_rready_i, s_bready_i,
	input  logic [ADDR_W-1:0] s_araddr_i, s_awaddr_i,
	input  logic [DATA_W-1:0] s_wdata_i,
	input  logic [STRB_W-1:0] s_wstrb_i,
	output logic [DATA_W-1:0] s_rdata_o,
	output axi_resp_e         s_rresp_o, s_bresp_o,
	// To the RAM
	output logic              m_ram_arvalid_o, m_ram_awvalid_o, m_ram_wvalid_o,
	input  logic              m_ram_arready_i, m_ram_awready_i, m_ram_wready_i,
	input  logic              m_ram_rvalid_i, m_ram_bvalid_i,
	output logic              m_ram_rready_o, m_ram_bready_o,
	output logic [ADDR_W-1:0] m_ram_araddr_o, m_ram_awaddr_o,
	output logic [DATA_W-1:0] m_ram_wdata_o,
	output logic [STRB_W-1:0] m_ram_wstrb_o,
	input  logic [DATA_W-1:0] m_ram_rdata_i,
	input  axi_resp_e         m_ram_rresp_i, m_ram_bresp_i,
	// To the boot controller
	output logic              m_boot_arvalid_o, m_boot_awvalid_o, m_boot_wvalid_o,
	input  logic              m_boot_arready_i, m_boot_awready_i, m_boot_wready_i,
	input  logic              m_boot_rvalid_i, m_boot_bvalid_i,
	output logic              m_boot_rready_o, m_boot_bready_o,
	output logic [ADDR_W-1:0] m_boot_araddr_o, m_boot_awaddr_o,
	output logic [DATA_W-1:0] m_boot_wdata_o,
	output logic [STRB_W-1:0] m_boot_wstrb_o,
	input  logic [DATA_W-1:0] m_boot_rdata_i,
	input  axi_resp_e         m_boot_rresp_i, m_boot_bresp_i
);

	slv_sel_e          sel_d, sel_q; // Live decode, and target of the open transaction
	logic              busy_q; // Address taken, response not yet
	logic              dec_rvalid_q, dec_bvalid_q; // Local DECERR responses
	logic              ar_go, aw_go;
	logic [ADDR_W-1:0] req_addr;

	assign req_addr = s_arvalid_i ? s_araddr_i : s_awaddr_i; // One request at a time

	// Range check, subtraction wraps so below-base misses too
	always_comb begin
		if ((req_addr - RAM_BASE) <= RAM_SPACE)
			sel_d = SEL_RAM;
		else if ((req_addr - BOOT_BASE) <= BOOT_SPACE)
			sel_d = SEL_BOOT;
		else
			sel_d = SEL_NONE; // UART, SPI, DDR end up here
	end

	// Requests only reach the chosen slave, and only when idle
	assign m_ram_arvalid_o  = s_arvalid_i & ~busy_q & (sel_d == SEL_RAM);
	assign m_ram_awvalid_o  = s_awvalid_i & ~busy_q & (sel_d == SEL_RAM);
	assign m_ram_wvalid_o   = s_wvalid_i & ~busy_q & (sel_d == SEL_RAM);
	assign m_boot_arvalid_o = s_arvalid_i & ~busy_q & (sel_d == SEL_BOOT);
	assign m_boot_awvalid_o = s_awvalid_i & ~busy_q & (sel_d == SEL_BOOT);
	assign m_boot_wvalid_o  = s_wvalid_i & ~busy_q & (sel_d == SEL_BOOT);
	assign m_ram_araddr_o   = s_araddr_i;
	assign m_ram_awaddr_o   = s_awaddr_i;
	assign m_ram_wdata_o    = s_wdata_i;
	assign m_ram_wstrb_o    = s_wstrb_i;
	assign m_boot_araddr_o  = s_araddr_i;
	assign m_boot_awaddr_o  = s_awaddr_i;
	assign m_boot_wdata_o   = s_wdata_i;
	assign m_boot_wstrb_o   = s_wstrb_i;

	always_comb begin
		s_arready_o = 1'b0;
		s_awready_o = 1'b0;
		s_wready_o  = 1'b0;
		if (!busy_q) begin
			case (sel_d)
				SEL_RAM: begin
					s_arready_o = m_ram_arready_i;
					s_awready_o = m_ram_awready_i;
					s_wready_o  = m_ram_wready_i;
				end
				SEL_BOOT: begin
					s_arready_o = m_boot_arready_i;
					s_awready_o = m_boot_awready_i;
					s_wready_o  = m_boot_wready_i;
				end
				default: begin
					s_arready_o = s_arvalid_i;
					s_awready_o = s_awvalid_i & s_wvalid_i; // Write data is swallowed
					s_wready_o  = s_awvalid_i & s_wvalid_i;
				end
			endcase
		end
	end

	assign ar_go = s_arvalid_i & s_arready_o;
	assign aw_go = s_awvalid_i & s_awready_o;

	// Response mux follows the captured select
	always_comb begin
		case (sel_q)
			SEL_RAM: begin
				s_rvalid_o = m_ram_rvalid_i;
				s_rdata_o  = m_ram_rdata_i;
				s_rresp_o  = m_ram_rresp_i;
				s_bvalid_o = m_ram_bvalid_i;
				s_bresp_o  = m_ram_bresp_i;
			end
			SEL_BOOT: begin
				s_rvalid_o = m_boot_rvalid_i;
				s_rdata_o  = m_boot_rdata_i;
				s_rresp_o  = m_boot_rresp_i;
				s_bvalid_o = m_boot_bvalid_i;
				s_bresp_o  = m_boot_bresp_i;
			end
			default: begin
				s_rvalid_o = dec_rvalid_q;
				s_rdata_o  = '0;
				s_rresp_o  = DECERR;
				s_bvalid_o = dec_bvalid_q;
				s_bresp_o  = DECERR;
			end
		endcase
	end

	assign m_ram_rready_o  = s_rready_i & (sel_q == SEL_RAM);
	assign m_ram_bready_o  = s_bready_i & (sel_q == SEL_RAM);
	assign m_boot_rready_o = s_rready_i & (sel_q == SEL_BOOT);
	assign m_boot_bready_o = s_bready_i & (sel_q == SEL_BOOT);

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			busy_q       <= 1'b0;
			sel_q        <= SEL_NONE;
			dec_rvalid_q <= 1'b0;
			dec_bvalid_q <= 1'b0;
		end else begin
			if (ar_go | aw_go) begin
				busy_q <= 1'b1;
				sel_q  <= sel_d;
			end else if ((s_rvalid_o & s_rready_i) | (s_bvalid_o & s_bready_i))
				busy_q <= 1'b0;
			if (ar_go)
				dec_rvalid_q <= (sel_d == SEL_NONE);
			else if (s_rready_i)
				dec_rvalid_q <= 1'b0;
			if (aw_go)
				dec_bvalid_q <= (sel_d == SEL_NONE);
			else if (s_bready_i)
				dec_bvalid_q <= 1'b0;
		end
	end

endmodule

/* axi_ram.sv */
`timescale 1ns/1ps

module axi_ram
	import axi_pkg::*;
	import soc_pkg::*;
(
	input  logic              clk_i,
	input  logic              reset_i,
	// AR and R
	input  logic              s_arvalid_i,
	output logic              s_arready_o,
	input  logic [ADDR_W-1:0] s_araddr_i,
	output logic              s_rvalid_o,
	input  logic              s_rready_i,
	output logic [DATA_W-1:0] s_rdata_o,
	output axi_resp_e         s_rresp_o,
	// AW, W and B
	input  logic              s_awvalid_i,
	output logic              s_awready_o,
	input  logic [ADDR_W-1:0] s_awaddr_i,
	input  logic              s_wvalid_i,
	output logic              s_wready_o,
	input  logic [DATA_W-1:0] s_wdata_i,
	input  logic [STRB_W-1:0] s_wstrb_i,
	output logic              s_bvalid_o,
	input  logic              s_bready_i,
	output axi_resp_e         s_bresp_o
);

	logic [DATA_W-1:0]    mem [RAM_WORDS];
	logic [DATA_W-1:0]    rdata_q;
	logic                 accept_q; // Free for a new request
	logic                 rvalid_q, bvalid_q;
	logic                 rd_go, wr_go;
	logic [RAM_IDX_W-1:0] rd_idx, wr_idx;

	assign rd_idx = s_araddr_i[RAM_IDX_W+1:2]; // Upper bits ignored, so 4 KiB alias
	assign wr_idx = s_awaddr_i[RAM_IDX_W+1:2];
	assign rd_go  = s_arvalid_i & accept_q;
	assign wr_go  = s_awvalid_i & s_wvalid_i & accept_q & ~s_arvalid_i; // Needs AW and W

	assign s_arready_o = accept_q;
	assign s_awready_o = wr_go;
	assign s_wready_o  = wr_go;

	always_ff @(posedge clk_i) begin
		if (wr_go) begin
			for (int i = 0; i < STRB_W; i++) begin
				if (s_wstrb_i[i])
					mem[wr_idx][8*i +: 8] <= s_wdata_i[8*i +: 8];
			end
		end
		if (rd_go)
			rdata_q <= mem[rd_idx];
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			accept_q <= 1'b0;
			rvalid_q <= 1'b0;
			bvalid_q <= 1'b0;
		end else begin
			if (rd_go)
				rvalid_q <= 1'b1;
			else if (s_rready_i)
				rvalid_q <= 1'b0;
			if (wr_go)
				bvalid_q <= 1'b1;
			else if (s_bready_i)
				bvalid_q <= 1'b0;
			// Reopen once nothing is left waiting for ready
			accept_q <= ~(rd_go | wr_go) & ~(rvalid_q & ~s_rready_i) & ~(bvalid_q & ~s_bready_i);
		end
	end

	assign s_rvalid_o = rvalid_q;
	assign s_rdata_o  = rdata_q;
	assign s_rresp_o  = OKAY; // Plain memory never refuses
	assign s_bvalid_o = bvalid_q;
	assign s_bresp_o  = OKAY;

endmodule

/* boot_ctrl.sv */
`timescale 1ns/1ps

module boot_ctrl
	import axi_pkg::*;
	import soc_pkg::*;
(
	input  logic                         clk_i,
	input  logic                         reset_i,
	input  logic [$bits(boot_src_e)-1:0] boot_source_i, // Strapping pins
	// AR and R
	input  logic                         s_arvalid_i,
	output logic                         s_arready_o,
	input  logic [ADDR_W-1:0]            s_araddr_i,
	output logic                         s_rvalid_o,
	input  logic                         s_rready_i,
	output logic [DATA_W-1:0]            s_rdata_o,
	output axi_resp_e                    s_rresp_o,
	// AW, W and B
	input  logic                         s_awvalid_i,
	output logic                         s_awready_o,
	input  logic [ADDR_W-1:0]            s_awaddr_i,
	input  logic                         s_wvalid_i,
	output logic                         s_wready_o,
	input  logic [DATA_W-1:0]            s_wdata_i,
	input  logic [STRB_W-1:0]            s_wstrb_i,
	output logic                         s_bvalid_o,
	input  logic                         s_bready_i,
	output axi_resp_e                    s_bresp_o
);

	boot_src_e         src_q;
	logic [DATA_W-1:0] vec_q, rdata_q;
	axi_resp_e         rresp_q, bresp_q;
	logic              accept_q, rvalid_q, bvalid_q;
	logic              rd_go, wr_go;
	logic [7:0]        rd_off, wr_off; // Offset inside the 256 byte window

	assign rd_off = s_araddr_i[7:0];
	assign wr_off = s_awaddr_i[7:0];
	assign rd_go  = s_arvalid_i & accept_q;
	assign wr_go  = s_awvalid_i & s_wvalid_i & accept_q & ~s_arvalid_i;

	assign s_arready_o = accept_q;
	assign s_awready_o = wr_go;
	assign s_wready_o  = wr_go;

	// Straps sampled for as long as reset is held
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			case (boot_source_i)
				BOOT_SPI: begin
					src_q <= BOOT_SPI;
					vec_q <= SPI_BASE;
				end
				BOOT_DDR: begin
					src_q <= BOOT_DDR;
					vec_q <= DDR_BASE;
				end
				default: begin
					src_q <= BOOT_SRAM; // Also covers the unused code 3
					vec_q <= RAM_BASE;
				end
			endcase
		end else if (wr_go && wr_off == BOOT_VEC_REG) begin
			for (int i = 0; i < STRB_W; i++) begin
				if (s_wstrb_i[i])
					vec_q[8*i +: 8] <= s_wdata_i[8*i +: 8];
			end
		end
	end

	// Response payload
	always_ff @(posedge clk_i) begin
		if (rd_go) begin
			case (rd_off)
				BOOT_SRC_REG: begin
					rdata_q <= {{(DATA_W-2){1'b0}}, src_q};
					rresp_q <= OKAY;
				end
				BOOT_VEC_REG: begin
					rdata_q <= vec_q;
					rresp_q <= OKAY;
				end
				default: begin
					rdata_q <= '0;
					rresp_q <= SLVERR; // Hole in the register map
				end
			endcase
		end
		if (wr_go) begin
			if (wr_off == BOOT_VEC_REG)
				bresp_q <= OKAY;
			else
				bresp_q <= SLVERR; // Source register is read only
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			accept_q <= 1'b0;
			rvalid_q <= 1'b0;
			bvalid_q <= 1'b0;
		end else begin
			if (rd_go)
				rvalid_q <= 1'b1;
			else if (s_rready_i)
				rvalid_q <= 1'b0;
			if (wr_go)
				bvalid_q <= 1'b1;
			else if (s_bready_i)
				bvalid_q <= 1'b0;
			accept_q <= ~(rd_go | wr_go) & ~(rvalid_q & ~s_rready_i) & ~(bvalid_q & ~s_bready_i);
		end
	end

	assign s_rvalid_o = rvalid_q;
	assign s_rdata_o  = rdata_q;
	assign s_rresp_o  = rresp_q;
	assign s_bvalid_o = bvalid_q;
	assign s_bresp_o  = bresp_q;

endmodule

/* soc_top.sv */
`timescale 1ns/1ps

module soc_top
	import axi_pkg::*;
	import soc_pkg::*;
(
	input  logic                         clk_i,
	input  logic                         reset_i,
	input  logic [$bits(boot_src_e)-1:0] boot_source_i, // 0 SPI, 1 SRAM, 2 DDR
	// CPU data port
	input  logic                         mem_rd_i,
	input  logic                         mem_wr_i,
	input  logic [ADDR_W-1:0]            mem_addr_i,
	input  logic [DATA_W-1:0]            mem_wdata_i,
	input  logic [STRB_W-1:0]            mem_byte_sel_i,
	output logic                         mem_ready_o,
	output logic [DATA_W-1:0]            mem_rdata_o,
	output logic                         bus_err_o
);

	// Bridge to decoder
	logic              bus_arvalid, bus_arready, bus_rvalid, bus_rready;
	logic              bus_awvalid, bus_awready, bus_wvalid, bus_wready;
	logic              bus_bvalid, bus_bready;
	logic [ADDR_W-1:0] bus_araddr, bus_awaddr;
	logic [DATA_W-1:0] bus_rdata, bus_wdata;
	logic [STRB_W-1:0] bus_wstrb;
	axi_resp_e         bus_rresp, bus_bresp;
	// Decoder to RAM
	logic              ram_arvalid, ram_arready, ram_rvalid, ram_rready;
	logic              ram_awvalid, ram_awready, ram_wvalid, ram_wready;
	logic              ram_bvalid, ram_bready;
	logic [ADDR_W-1:0] ram_araddr, ram_awaddr;
	logic [DATA_W-1:0] ram_rdata, ram_wdata;
	logic [STRB_W-1:0] ram_wstrb;
	axi_resp_e         ram_rresp, ram_bresp;
	// Decoder to boot controller
	logic              boot_arvalid, boot_arready, boot_rvalid, boot_rready;
	logic              boot_awvalid, boot_awready, boot_wvalid, boot_wready;
	logic              boot_bvalid, boot_bready;
	logic [ADDR_W-1:0] boot_araddr, boot_awaddr;
	logic [DATA_W-1:0] boot_rdata, boot_wdata;
	logic [STRB_W-1:0] boot_wstrb;
	axi_resp_e         boot_rresp, boot_bresp;

	cpu_mem_bridge inst_bridge (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.mem_rd_i(mem_rd_i), .mem_wr_i(mem_wr_i), .mem_addr_i(mem_addr_i),
		.mem_wdata_i(mem_wdata_i), .mem_byte_sel_i(mem_byte_sel_i),
		.mem_ready_o(mem_ready_o), .mem_rdata_o(mem_rdata_o), .bus_err_o(bus_err_o),
		.m_arvalid_o(bus_arvalid), .m_arready_i(bus_arready), .m_araddr_o(bus_araddr),
		.m_rvalid_i(bus_rvalid), .m_rready_o(bus_rready),
		.m_rdata_i(bus_rdata), .m_rresp_i(bus_rresp),
		.m_awvalid_o(bus_awvalid), .m_awready_i(bus_awready), .m_awaddr_o(bus_awaddr),
		.m_wvalid_o(bus_wvalid), .m_wready_i(bus_wready),
		.m_wdata_o(bus_wdata), .m_wstrb_o(bus_wstrb),
		.m_bvalid_i(bus_bvalid), .m_bready_o(bus_bready), .m_bresp_i(bus_bresp)
	);

	// Single master, two slaves, unmapped ranges get DECERR
	axi_decoder inst_decoder (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.s_arvalid_i(bus_arvalid), .s_arready_o(bus_arready), .s_araddr_i(bus_araddr),
		.s_rvalid_o(bus_rvalid), .s_rready_i(bus_rready),
		.s_rdata_o(bus_rdata), .s_rresp_o(bus_rresp),
		.s_awvalid_i(bus_awvalid), .s_awready_o(bus_awready), .s_awaddr_i(bus_awaddr),
		.s_wvalid_i(bus_wvalid), .s_wready_o(bus_wready),
		.s_wdata_i(bus_wdata), .s_wstrb_i(bus_wstrb),
		.s_bvalid_o(bus_bvalid), .s_bready_i(bus_bready), .s_bresp_o(bus_bresp),
		.m_ram_arvalid_o(ram_arvalid), .m_ram_arready_i(ram_arready),
		.m_ram_araddr_o(ram_araddr),
		.m_ram_rvalid_i(ram_rvalid), .m_ram_rready_o(ram_rready),
		.m_ram_rdata_i(ram_rdata), .m_ram_rresp_i(ram_rresp),
		.m_ram_awvalid_o(ram_awvalid), .m_ram_awready_i(ram_awready),
		.m_ram_awaddr_o(ram_awaddr),
		.m_ram_wvalid_o(ram_wvalid), .m_ram_wready_i(ram_wready),
		.m_ram_wdata_o(ram_wdata), .m_ram_wstrb_o(ram_wstrb),
		.m_ram_bvalid_i(ram_bvalid), .m_ram_bready_o(ram_bready), .m_ram_bresp_i(ram_bresp),
		.m_boot_arvalid_o(boot_arvalid), .m_boot_arready_i(boot_arready),
		.m_boot_araddr_o(boot_araddr),
		.m_boot_rvalid_i(boot_rvalid), .m_boot_rready_o(boot_rready),
		.m_boot_rdata_i(boot_rdata), .m_boot_rresp_i(boot_rresp),
		.m_boot_awvalid_o(boot_awvalid), .m_boot_awready_i(boot_awready),
		.m_boot_awaddr_o(boot_awaddr),
		.m_boot_wvalid_o(boot_wvalid), .m_boot_wready_i(boot_wready),
		.m_boot_wdata_o(boot_wdata), .m_boot_wstrb_o(boot_wstrb),
		.m_boot_bvalid_i(boot_bvalid), .m_boot_bready_o(boot_bready),
		.m_boot_bresp_i(boot_bresp)
	);

	axi_ram inst_ram (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.s_arvalid_i(ram_arvalid), .s_arready_o(ram_arready), .s_araddr_i(ram_araddr),
		.s_rvalid_o(ram_rvalid), .s_rready_i(ram_rready),
		.s_rdata_o(ram_rdata), .s_rresp_o(ram_rresp),
		.s_awvalid_i(ram_awvalid), .s_awready_o(ram_awready), .s_awaddr_i(ram_awaddr),
		.s_wvalid_i(ram_wvalid), .s_wready_o(ram_wready),
		.s_wdata_i(ram_wdata), .s_wstrb_i(ram_wstrb),
		.s_bvalid_o(ram_bvalid), .s_bready_i(ram_bready), .s_bresp_o(ram_bresp)
	);

	boot_ctrl inst_boot_ctrl (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.boot_source_i(boot_source_i),
		.s_arvalid_i(boot_arvalid), .s_arready_o(boot_arready), .s_araddr_i(boot_araddr),
		.s_rvalid_o(boot_rvalid), .s_rready_i(boot_rready),
		.s_rdata_o(boot_rdata), .s_rresp_o(boot_rresp),
		.s_awvalid_i(boot_awvalid), .s_awready_o(boot_awready), .s_awaddr_i(boot_awaddr),
		.s_wvalid_i(boot_wvalid), .s_wready_o(boot_wready),
		.s_wdata_i(boot_wdata), .s_wstrb_i(boot_wstrb),
		.s_bvalid_o(boot_bvalid), .s_bready_i(boot_bready), .s_bresp_o(boot_bresp)
	);

endmodule

/* tb_soc_top.sv */
`timescale 1ns/1ps

module tb_soc_top
	import axi_pkg::*;
	import soc_pkg::*;
();

	localparam int RST_CYCLES  = 10;
	localparam int MAX_LINES   = 64; // Golden file capacity
	localparam int LINE_CYCLES = 50; // Budget per golden line
	localparam int VEC_W       = 108; // op, addr, wdata, bsel, rdata, err

	logic                         clk_i = 1'b0;
	logic                         reset_i;
	logic [$bits(boot_src_e)-1:0] boot_source_i;
	logic                         mem_rd_i;
	logic                         mem_wr_i;
	logic [ADDR_W-1:0]            mem_addr_i;
	logic [DATA_W-1:0]            mem_wdata_i;
	logic [STRB_W-1:0]            mem_byte_sel_i;
	logic                         mem_ready_o;
	logic [DATA_W-1:0]            mem_rdata_o;
	logic                         bus_err_o;

	logic [VEC_W-1:0] golden [MAX_LINES]; // Line 0 is the boot strap
	int               n_lines;
	int               cur_line; // Golden line under test
	logic             loaded = 1'b0; // Golden file parsed

	soc_top dut (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.boot_source_i(boot_source_i),
		.mem_rd_i(mem_rd_i),
		.mem_wr_i(mem_wr_i),
		.mem_addr_i(mem_addr_i),
		.mem_wdata_i(mem_wdata_i),
		.mem_byte_sel_i(mem_byte_sel_i),
		.mem_ready_o(mem_ready_o),
		.mem_rdata_o(mem_rdata_o),
		.bus_err_o(bus_err_o)
	);

	always #20 clk_i = ~clk_i; // 40 ns period

	// Compare and stop at the first mismatch
	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Fail %s on golden line %0d: got 0x%08h, expected 0x%08h",
				name, cur_line, got, exp);
			$display("Simulation failed");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	// One CPU access, strobe held until the ready pulse
	task automatic run_access(input logic [VEC_W-1:0] vec);
		logic [3:0]  op;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0]  bsel;
		logic [31:0] exp_rdata;
		logic [3:0]  exp_err;
		int          waited;
		{op, addr, wdata, bsel, exp_rdata, exp_err} = vec;
		waited = 0;
		@(posedge clk_i);
		mem_rd_i       <= (op == 4'h1);
		mem_wr_i       <= (op == 4'h2);
		mem_addr_i     <= addr;
		mem_wdata_i    <= wdata;
		mem_byte_sel_i <= bsel;
		// Outputs looked at mid-cycle, away from the edge
		do begin
			@(negedge clk_i);
			waited++;
			if (waited > LINE_CYCLES) begin
				$display("No ready pulse from the DUT within %0d cycles on golden line %0d",
					LINE_CYCLES, cur_line);
				$display("Simulation failed");
				$fatal(1, "Access timed out");
			end
		end while (!mem_ready_o);
		if (op == 4'h1)
			check("mem_rdata_o", mem_rdata_o, exp_rdata); // Write data return not checked
		check("bus_err_o", {31'b0, bus_err_o}, {28'b0, exp_err});
		@(posedge clk_i);
		mem_rd_i <= 1'b0; // Strobe drops on the edge after ready
		mem_wr_i <= 1'b0;
	endtask

	initial begin
		int i;
		void'($urandom(24));
		reset_i        <= 1'b1;
		mem_rd_i       <= 1'b0;
		mem_wr_i       <= 1'b0;
		mem_addr_i     <= '0;
		mem_wdata_i    <= '0;
		mem_byte_sel_i <= '0;
		for (i = 0; i < MAX_LINES; i++)
			golden[i] = '0; // Op 0 marks the end
		$readmemh("soc_golden.txt", golden);
		n_lines = 1;
		while (n_lines < MAX_LINES && golden[n_lines][VEC_W-1 -: 4] inside {4'h1, 4'h2})
			n_lines++;
		if (n_lines < 2) begin
			$display("The golden file holds no accesses");
			$display("Simulation failed");
			$fatal(1, "Empty golden file");
		end
		boot_source_i <= golden[0][1:0]; // Straps sampled during reset
		loaded = 1'b1;
		repeat (RST_CYCLES) @(posedge clk_i);
		reset_i <= 1'b0;
		for (i = 1; i < n_lines; i++) begin
			repeat ($urandom % 4) @(posedge clk_i); // Zero to three idle cycles
			cur_line = i;
			run_access(golden[i]);
		end
		$display("Simulation passed");
		$finish;
	end

	// Watchdog, scaled by the golden file length
	initial begin
		wait (loaded);
		repeat (RST_CYCLES + n_lines * LINE_CYCLES) @(posedge clk_i);
		$display("Watchdog expired after %0d cycles before all accesses finished",
			RST_CYCLES + n_lines * LINE_CYCLES);
		$display("Simulation failed");
		$fatal(1, "Watchdog timeout");
	end

endmodule

/* soc_golden.txt */
// First line: boot source strap (0 SPI, 1 SRAM, 2 DDR)
// Then: op (1 read, 2 write) _ addr _ wdata _ byte sel _ expected rdata _ expected error
2
2_00000000_11223344_f_00000000_0
1_00000000_00000000_0_11223344_0
2_00000010_deadbeef_f_00000000_0
1_00000010_00000000_0_deadbeef_0
2_00000010_aabbccdd_5_00000000_0
1_00000010_00000000_0_debbbedd_0
2_00000010_55000000_8_00000000_0
1_00000010_00000000_0_55bbbedd_0
1_00030000_00000000_0_00000002_0
1_00030004_00000000_0_10000000_0
2_00030004_00001234_3_00000000_0
1_00030004_00000000_0_10001234_0
2_00030004_80000000_f_00000000_0
1_00030004_00000000_0_80000000_0
2_00030000_00000001_f_00000000_1
1_00030008_00000000_0_00000000_1
1_00030000_00000000_0_00000002_0
1_00040000_00000000_0_00000000_1
2_00040000_ffffffff_f_00000000_1
1_00060000_00000000_0_00000000_1
2_00060000_ffffffff_f_00000000_1
1_10000000_00000000_0_00000000_1
2_10000000_ffffffff_f_00000000_1
1_00000000_00000000_0_11223344_0
1_00001000_00000000_0_11223344_0
2_00001000_99887766_f_00000000_0
1_00000000_00000000_0_99887766_0

/* project.f */
axi_pkg.sv
soc_pkg.sv
cpu_mem_bridge.sv
axi_decoder.sv
axi_ram.sv
boot_ctrl.sv
soc_top.sv
tb_soc_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the SoC memory path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module tb_soc_top -o tb_soc_top
if [ $? -ne 0 ]; then
	echo "Verilator build did not complete"
	exit 1
fi

out=$(./obj_dir/tb_soc_top 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation binary exited with status $status"
	exit 1
fi

printf '%s\n' "$out" | grep -qx "Simulation passed" || exit 1
exit 0
